//--- build.f
source/mem_bridge_pkg.sv
source/axi_read_if.sv
source/inst_uncache.sv
source/data_uncache.sv
source/axi_read_arbiter.sv
source/mem_bridge_top.sv
testbench/axi_mem_model.sv
testbench/tb_mem_bridge_sva.sv
testbench/tb_mem_bridge.sv

//--- run.sh
#!/bin/sh
# Build and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_mem_bridge -f build.f -o sim_mem_bridge
if [ $? -ne 0 ]; then
    echo "Build failed"
    exit 1
fi

output=$(./obj_dir/sim_mem_bridge +verilator+error+limit+100)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "^Verification passed$"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1

//--- source/axi_read_arbiter.sv
`default_nettype none

module axi_read_arbiter import mem_bridge_pkg::*; (
    input  logic                aclk,
    input  logic                rst,

    axi_read_if.slave           inst_rd,
    axi_read_if.slave           data_rd,

    output logic [ID_W-1:0]     arid,
    output logic [ADDR_W-1:0]   araddr,
    output logic [AXSIZE_W-1:0] arsize,
    output logic                arvalid,
    input  logic                arready,
    input  logic [ID_W-1:0]     rid,
    input  logic [DATA_W-1:0]   rdata,
    input  logic                rvalid,
    output logic                rready
);

    logic [GNT_W-1:0] gnt_q;
    logic [GNT_W-1:0] gnt;
    logic             sel_inst;
    logic             sel_data;

    // Held grant wins, else data before inst
    always_comb begin
        gnt = gnt_q;
        if (gnt_q == GNT_NONE) begin
            if (data_rd.arvalid) begin
                gnt = GNT_DATA;
            end else if (inst_rd.arvalid) begin
                gnt = GNT_INST;
            end
        end
    end

    assign sel_inst = (gnt == GNT_INST);
    assign sel_data = (gnt == GNT_DATA);

    always_comb begin
        arid    = '0;
        araddr  = '0;
        arsize  = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        if (sel_data) begin
            arid    = data_rd.arid;
            araddr  = data_rd.araddr;
            arsize  = data_rd.arsize;
            arvalid = data_rd.arvalid;
            rready  = data_rd.rready;
        end else if (sel_inst) begin
            arid    = inst_rd.arid;
            araddr  = inst_rd.araddr;
            arsize  = inst_rd.arsize;
            arvalid = inst_rd.arvalid;
            rready  = inst_rd.rready;
        end
    end

    // Ungranted side sees no handshake
    assign inst_rd.arready = sel_inst && arready;
    assign inst_rd.rvalid  = sel_inst && rvalid;
    assign inst_rd.rdata   = sel_inst ? rdata : '0;
    assign inst_rd.rid     = rid;

    assign data_rd.arready = sel_data && arready;
    assign data_rd.rvalid  = sel_data && rvalid;
    assign data_rd.rdata   = sel_data ? rdata : '0;
    assign data_rd.rid     = rid;

    always_ff @(posedge aclk) begin
        if (rst) begin
            gnt_q <= GNT_NONE;
        end else if (rvalid && rready) begin
            gnt_q <= GNT_NONE;
        end else begin
            gnt_q <= gnt;
        end
    end

endmodule

`default_nettype wire

//--- source/axi_read_if.sv
`default_nettype none

interface axi_read_if import mem_bridge_pkg::*; ();

    logic [ID_W-1:0]     arid;
    logic [ADDR_W-1:0]   araddr;
    logic [AXSIZE_W-1:0] arsize;
    logic                arvalid;
    logic                arready;

    logic [ID_W-1:0]     rid;
    logic [DATA_W-1:0]   rdata;
    logic                rvalid;
    logic                rready;

    modport master (
        output arid, araddr, arsize, arvalid, rready,
        input  arready, rid, rdata, rvalid
    );

    // Arbiter side
    modport slave (
        input  arid, araddr, arsize, arvalid, rready,
        output arready, rid, rdata, rvalid
    );

endinterface

`default_nettype wire

//--- source/data_uncache.sv
`default_nettype none

module data_uncache import mem_bridge_pkg::*; (
    input  logic                aclk,
    input  logic                rst,

    input  logic                data_req,
    input  logic                data_wr,
    input  logic [SIZE_W-1:0]   data_size,
    input  logic [ADDR_W-1:0]   data_addr,
    input  logic [DATA_W-1:0]   data_wdata,
    input  logic [STRB_W-1:0]   data_wstrb,
    output logic [DATA_W-1:0]   data_rdata,
    output logic                data_addr_ok,
    output logic                data_data_ok,

    axi_read_if.master          rd,

    output logic [ID_W-1:0]     awid,
    output logic [ADDR_W-1:0]   awaddr,
    output logic [AXSIZE_W-1:0] awsize,
    output logic                awvalid,
    input  logic                awready,
    output logic [DATA_W-1:0]   wdata,
    output logic [STRB_W-1:0]   wstrb,
    output logic                wvalid,
    input  logic                wready,
    input  logic                bvalid,
    output logic                bready
);

    logic [ST_W-1:0]     state;
    logic [ADDR_W-1:0]   addr_q;
    logic [SIZE_W-1:0]   size_q;
    logic [DATA_W-1:0]   wdata_q;
    logic [STRB_W-1:0]   wstrb_q;
    logic [AXSIZE_W-1:0] axsize;
    logic                aw_done;
    logic                w_done;
    logic                accept;
    logic                ar_fire;
    logic                r_fire;
    logic                aw_fire;
    logic                w_fire;
    logic                b_fire;

    assign data_addr_ok = (state == ST_IDLE);
    assign accept       = data_req && data_addr_ok;

    assign ar_fire = rd.arvalid && rd.arready;
    assign r_fire  = rd.rvalid && rd.rready;
    assign aw_fire = awvalid && awready;
    assign w_fire  = wvalid && wready;
    assign b_fire  = bvalid && bready;

    assign axsize = {{(AXSIZE_W - SIZE_W){1'b0}}, size_q};

    assign rd.arid    = DATA_ID;
    assign rd.araddr  = addr_q;
    assign rd.arsize  = axsize;
    assign rd.arvalid = (state == ST_ADDR);
    assign rd.rready  = (state == ST_DATA) && !data_data_ok;

    assign awid    = DATA_ID;
    assign awaddr  = addr_q;
    assign awsize  = axsize;
    assign wdata   = wdata_q;
    assign wstrb   = wstrb_q;

    // aw and w open together, each closes on its own transfer
    assign awvalid = (state == ST_WRITE) && !aw_done;
    assign wvalid  = (state == ST_WRITE) && !w_done;
    assign bready  = (state == ST_BRESP) && !data_data_ok;

    always_ff @(posedge aclk) begin
        if (rst) begin
            state        <= ST_IDLE;
            aw_done      <= 1'b0;
            w_done       <= 1'b0;
            data_data_ok <= 1'b0;
        end else begin
            data_data_ok <= r_fire || b_fire;
            case (state)
                ST_IDLE: begin
                    if (accept) begin
                        state   <= data_wr ? ST_WRITE : ST_ADDR;
                        aw_done <= 1'b0;
                        w_done  <= 1'b0;
                    end
                end
                ST_ADDR: begin
                    if (ar_fire) begin
                        state <= ST_DATA;
                    end
                end
                ST_WRITE: begin
                    aw_done <= aw_done || aw_fire;
                    w_done  <= w_done || w_fire;
                    if ((aw_done || aw_fire) && (w_done || w_fire)) begin
                        state <= ST_BRESP;
                    end
                end
                ST_DATA, ST_BRESP: begin
                    if (data_data_ok) begin
                        state <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // Whole request captured at acceptance
    always_ff @(posedge aclk) begin
        if (accept) begin
            addr_q  <= data_addr;
            size_q  <= data_size;
            wdata_q <= data_wdata;
            wstrb_q <= data_wstrb;
        end
        if (r_fire) begin
            data_rdata <= rd.rdata;
        end
    end

endmodule

`default_nettype wire

//--- source/inst_uncache.sv
`default_nettype none

module inst_uncache import mem_bridge_pkg::*; (
    input  logic              aclk,
    input  logic              rst,

    input  logic              inst_req,
    input  logic [ADDR_W-1:0] inst_addr,
    output logic [DATA_W-1:0] inst_rdata,
    output logic              inst_addr_ok,
    output logic              inst_data_ok,

    axi_read_if.master        rd
);

    logic [ST_W-1:0]   state;
    logic [ADDR_W-1:0] addr_q;
    logic              accept;
    logic              ar_fire;
    logic              r_fire;

    assign inst_addr_ok = (state == ST_IDLE);
    assign accept       = inst_req && inst_addr_ok;

    assign ar_fire = rd.arvalid && rd.arready;
    assign r_fire  = rd.rvalid && rd.rready;

    // Always one full word per fetch
    assign rd.arid    = INST_ID;
    assign rd.araddr  = addr_q;
    assign rd.arsize  = {{(AXSIZE_W - SIZE_W){1'b0}}, SIZE_WORD};
    assign rd.arvalid = (state == ST_ADDR);

    // Held low during the data_ok cycle
    assign rd.rready  = (state == ST_DATA) && !inst_data_ok;

    always_ff @(posedge aclk) begin
        if (rst) begin
            state        <= ST_IDLE;
            inst_data_ok <= 1'b0;
        end else begin
            inst_data_ok <= r_fire;
            case (state)
                ST_IDLE: begin
                    if (accept) begin
                        state <= ST_ADDR;
                    end
                end
                ST_ADDR: begin
                    if (ar_fire) begin
                        state <= ST_DATA;
                    end
                end
                ST_DATA: begin
                    // Leave once the pulse has gone out
                    if (inst_data_ok) begin
                        state <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if (accept) begin
            addr_q <= inst_addr;
        end
        if (r_fire) begin
            inst_rdata <= rd.rdata;
        end
    end

endmodule

`default_nettype wire

//--- source/mem_bridge_pkg.sv
`default_nettype none

package mem_bridge_pkg;

    localparam int ADDR_W   = 32;
    localparam int DATA_W   = 32;
    localparam int STRB_W   = 4;
    localparam int ID_W     = 4;
    localparam int SIZE_W   = 2;
    localparam int AXSIZE_W = 3;

    // Read ids per source
    localparam logic [ID_W-1:0] INST_ID = 4'd0;
    localparam logic [ID_W-1:0] DATA_ID = 4'd1;

    // Byte is 0 and half-word is 1
    localparam logic [SIZE_W-1:0] SIZE_WORD = 2'd2;

    // Uncache controller states
    localparam int ST_W = 3;
    localparam logic [ST_W-1:0] ST_IDLE  = 3'd0;
    localparam logic [ST_W-1:0] ST_ADDR  = 3'd1;
    localparam logic [ST_W-1:0] ST_DATA  = 3'd2;
    localparam logic [ST_W-1:0] ST_WRITE = 3'd3;
    localparam logic [ST_W-1:0] ST_BRESP = 3'd4;

    // Read grant owner
    localparam int GNT_W = 2;
    localparam logic [GNT_W-1:0] GNT_NONE = 2'd0;
    localparam logic [GNT_W-1:0] GNT_INST = 2'd1;
    localparam logic [GNT_W-1:0] GNT_DATA = 2'd2;

endpackage

`default_nettype wire

//--- source/mem_bridge_top.sv
`default_nettype none

module mem_bridge_top import mem_bridge_pkg::*; (
    input  logic                aclk,
    input  logic                rst,

    input  logic                inst_req,
    input  logic [ADDR_W-1:0]   inst_addr,
    output logic [DATA_W-1:0]   inst_rdata,
    output logic                inst_addr_ok,
    output logic                inst_data_ok,

    input  logic                data_req,
    input  logic                data_wr,
    input  logic [SIZE_W-1:0]   data_size,
    input  logic [ADDR_W-1:0]   data_addr,
    input  logic [DATA_W-1:0]   data_wdata,
    input  logic [STRB_W-1:0]   data_wstrb,
    output logic [DATA_W-1:0]   data_rdata,
    output logic                data_addr_ok,
    output logic                data_data_ok,

    output logic [ID_W-1:0]     arid,
    output logic [ADDR_W-1:0]   araddr,
    output logic [AXSIZE_W-1:0] arsize,
    output logic                arvalid,
    input  logic                arready,
    input  logic [ID_W-1:0]     rid,
    input  logic [DATA_W-1:0]   rdata,
    input  logic                rvalid,
    output logic                rready,

    output logic [ID_W-1:0]     awid,
    output logic [ADDR_W-1:0]   awaddr,
    output logic [AXSIZE_W-1:0] awsize,
    output logic                awvalid,
    input  logic                awready,
    output logic [DATA_W-1:0]   wdata,
    output logic [STRB_W-1:0]   wstrb,
    output logic                wvalid,
    input  logic                wready,
    input  logic                bvalid,
    output logic                bready
);

    axi_read_if inst_rd ();
    axi_read_if data_rd ();

    inst_uncache u_inst_uncache (
        .aclk         (aclk),
        .rst          (rst),
        .inst_req     (inst_req),
        .inst_addr    (inst_addr),
        .inst_rdata   (inst_rdata),
        .inst_addr_ok (inst_addr_ok),
        .inst_data_ok (inst_data_ok),
        .rd           (inst_rd)
    );

    // Only writer in the design, so aw/w/b go straight out
    data_uncache u_data_uncache (
        .aclk         (aclk),
        .rst          (rst),
        .data_req     (data_req),
        .data_wr      (data_wr),
        .data_size    (data_size),
        .data_addr    (data_addr),
        .data_wdata   (data_wdata),
        .data_wstrb   (data_wstrb),
        .data_rdata   (data_rdata),
        .data_addr_ok (data_addr_ok),
        .data_data_ok (data_data_ok),
        .rd           (data_rd),
        .awid         (awid),
        .awaddr       (awaddr),
        .awsize       (awsize),
        .awvalid      (awvalid),
        .awready      (awready),
        .wdata        (wdata),
        .wstrb        (wstrb),
        .wvalid       (wvalid),
        .wready       (wready),
        .bvalid       (bvalid),
        .bready       (bready)
    );

    axi_read_arbiter u_axi_read_arbiter (
        .aclk    (aclk),
        .rst     (rst),
        .inst_rd (inst_rd),
        .data_rd (data_rd),
        .arid    (arid),
        .araddr  (araddr),
        .arsize  (arsize),
        .arvalid (arvalid),
        .arready (arready),
        .rid     (rid),
        .rdata   (rdata),
        .rvalid  (rvalid),
        .rready  (rready)
    );

endmodule

`default_nettype wire

//--- testbench/axi_mem_model.sv
`default_nettype none

module axi_mem_model import mem_bridge_pkg::*; (
    input  logic              aclk,
    input  logic              rst,
    input  logic [ID_W-1:0]   arid,
    input  logic [ADDR_W-1:0] araddr,
    input  logic              arvalid,
    output logic              arready,
    output logic [ID_W-1:0]   rid,
    output logic [DATA_W-1:0] rdata,
    output logic              rvalid,
    input  logic              rready,
    input  logic [ADDR_W-1:0] awaddr,
    input  logic              awvalid,
    output logic              awready,
    input  logic [DATA_W-1:0] wdata,
    input  logic [STRB_W-1:0] wstrb,
    input  logic              wvalid,
    output logic              wready,
    output logic              bvalid,
    input  logic              bready
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int M_IDLE = 0;
    localparam int M_AR   = 1;
    localparam int M_R    = 2;
    localparam int M_W    = 3;
    localparam int M_B    = 4;

    logic [DATA_W-1:0] mem [0:255];
    logic [7:0]        rd_idx;
    logic [7:0]        wr_idx;
    logic [DATA_W-1:0] wr_data;
    logic [STRB_W-1:0] wr_strb;
    logic              aw_seen;
    logic              w_seen;
    logic              resp_taken;
    int                state;
    int                delay;

    function automatic int pick_delay();
        return $urandom_range(3, 0);
    endfunction

    // Each word starts as the inverse of its byte address
    initial begin
        for (int i = 0; i < 256; i++) begin
            mem[i] = ~(32'(i) << 2);
        end
        state      = M_IDLE;
        arready    = 1'b0;
        rvalid     = 1'b0;
        awready    = 1'b0;
        wready     = 1'b0;
        bvalid     = 1'b0;
        rid        = '0;
        rdata      = '0;
        resp_taken = 1'b0;
    end

    // Valid from the DUT seen here holds through the next rising edge
    always @(negedge aclk) begin
        if (rst) begin
            state      = M_IDLE;
            arready    = 1'b0;
            rvalid     = 1'b0;
            awready    = 1'b0;
            wready     = 1'b0;
            bvalid     = 1'b0;
            resp_taken = 1'b0;
        end else begin
            case (state)
                M_IDLE: begin
                    delay   = pick_delay();
                    aw_seen = 1'b0;
                    w_seen  = 1'b0;
                    if (arvalid) begin
                        state = M_AR;
                    end else if (awvalid || wvalid) begin
                        state = M_W;
                    end
                end
                M_AR: begin
                    if (arready) begin
                        // Address went over at the last rising edge
                        arready = 1'b0;
                        delay   = pick_delay();
                        state   = M_R;
                    end else if (delay == 0) begin
                        arready = 1'b1;
                        rd_idx  = araddr[9:2];
                        rid     = arid;
                    end else begin
                        delay--;
                    end
                end
                M_R: begin
                    if (resp_taken) begin
                        rvalid = 1'b0;
                        state  = M_IDLE;
                    end else if (!rvalid && delay == 0) begin
                        rvalid = 1'b1;
                        rdata  = mem[rd_idx];
                    end else if (!rvalid) begin
                        delay--;
                    end
                end
                M_W: begin
                    if (awready) begin
                        awready = 1'b0;
                        aw_seen = 1'b1;
                    end
                    if (wready) begin
                        wready = 1'b0;
                        w_seen = 1'b1;
                    end
                    if (aw_seen && w_seen) begin
                        for (int b = 0; b < STRB_W; b++) begin
                            if (wr_strb[b]) begin
                                mem[wr_idx][8*b +: 8] = wr_data[8*b +: 8];
                            end
                        end
                        delay = pick_delay();
                        state = M_B;
                    end else if (delay == 0) begin
                        if (awvalid && !aw_seen) begin
                            awready = 1'b1;
                            wr_idx  = awaddr[9:2];
                        end
                        if (wvalid && !w_seen) begin
                            wready  = 1'b1;
                            wr_data = wdata;
                            wr_strb = wstrb;
                        end
                    end else begin
                        delay--;
                    end
                end
                M_B: begin
                    if (resp_taken) begin
                        bvalid = 1'b0;
                        state  = M_IDLE;
                    end else if (!bvalid && delay == 0) begin
                        bvalid = 1'b1;
                    end else if (!bvalid) begin
                        delay--;
                    end
                end
                default: begin
                    state = M_IDLE;
                end
            endcase
            // Response handshake that the coming rising edge completes
            resp_taken = (rvalid && rready) || (bvalid && bready);
        end
    end

endmodule

`default_nettype wire

//--- testbench/tb_mem_bridge.sv
`default_nettype none

module tb_mem_bridge import mem_bridge_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    // About 40 requests of at most 20 cycles each, plus margin
    localparam int MAX_CYCLES = 2000;

    logic                aclk;
    logic                rst;
    logic                inst_req, inst_addr_ok, inst_data_ok;
    logic [ADDR_W-1:0]   inst_addr;
    logic [DATA_W-1:0]   inst_rdata;
    logic                data_req, data_wr, data_addr_ok, data_data_ok;
    logic [SIZE_W-1:0]   data_size;
    logic [ADDR_W-1:0]   data_addr;
    logic [DATA_W-1:0]   data_wdata, data_rdata;
    logic [STRB_W-1:0]   data_wstrb;
    logic [ID_W-1:0]     arid, rid, awid;
    logic [ADDR_W-1:0]   araddr, awaddr;
    logic [AXSIZE_W-1:0] arsize, awsize;
    logic                arvalid, arready, rvalid, rready;
    logic                awvalid, awready, wvalid, wready, bvalid, bready;
    logic [DATA_W-1:0]   rdata, wdata;
    logic [STRB_W-1:0]   wstrb;

    logic [DATA_W-1:0]   shadow [0:255];
    // Seen flag, size and id of the last address transfer
    logic [AXSIZE_W+ID_W:0] ar_info [0:255];
    logic [AXSIZE_W+ID_W:0] aw_info;
    int                  cycles = 0;

    mem_bridge_top u_dut (.*);
    axi_mem_model u_mem (.*);
    bind mem_bridge_top tb_mem_bridge_sva u_sva (.*);

    always #50 aclk = ~aclk;

    always @(negedge aclk) begin
        cycles++;
        if (u_dut.u_sva.fail_count != 0) begin
            $display("A bus protocol assertion failed at %0t ns", $time);
            $display("Verification failed");
            $fatal(1, "protocol assertion failure");
        end else if (cycles >= MAX_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
            $display("Verification failed");
            $fatal(1, "timeout");
        end
    end

    // Read transfers kept per word index, so two ports can overlap
    always @(posedge aclk) begin
        if (arvalid && arready) begin
            ar_info[araddr[9:2]] = {1'b1, arsize, arid};
        end
        if (awvalid && awready) begin
            aw_info = {1'b1, awsize, awid};
        end
    end

    task automatic compare(input logic [DATA_W-1:0] actual, input logic [DATA_W-1:0] expected,
                           input string what);
        if (actual !== expected) begin
            $display("ERROR at %0t ns: %s: got %h, expected %h", $time, what, actual, expected);
            $display("Verification failed");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    function automatic logic [DATA_W-1:0] merge_bytes(input logic [DATA_W-1:0] old_word,
                                                      input logic [DATA_W-1:0] new_word,
                                                      input logic [STRB_W-1:0] strb);
        logic [DATA_W-1:0] result;
        result = old_word;
        for (int b = 0; b < STRB_W; b++) begin
            if (strb[b]) begin
                result[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return result;
    endfunction

    // Called on a falling edge and returns on one
    task automatic fetch_word(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] value);
        while (!inst_addr_ok) begin
            @(negedge aclk);
        end
        ar_info[addr[9:2]] = '0;
        inst_req  = 1'b1;
        inst_addr = addr;
        @(negedge aclk);
        inst_req = 1'b0;
        while (!inst_data_ok) begin
            @(negedge aclk);
        end
        value = inst_rdata;
        compare(ar_info[addr[9:2]], {1'b1, 3'd2, INST_ID}, "fetch arsize and arid");
        @(negedge aclk);
    endtask

    task automatic access_data(input logic wr, input logic [SIZE_W-1:0] size,
                               input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] wdat,
                               input logic [STRB_W-1:0] strb, output logic [DATA_W-1:0] value);
        while (!data_addr_ok) begin
            @(negedge aclk);
        end
        if (wr) begin
            aw_info = '0;
        end else begin
            ar_info[addr[9:2]] = '0;
        end
        data_req   = 1'b1;
        data_wr    = wr;
        data_size  = size;
        data_addr  = addr;
        data_wdata = wdat;
        data_wstrb = strb;
        @(negedge aclk);
        data_req = 1'b0;
        while (!data_data_ok) begin
            @(negedge aclk);
        end
        value = data_rdata;
        if (wr) begin
            compare(aw_info, {1'b1, 1'b0, size, DATA_ID}, "store awsize and awid");
        end else begin
            compare(ar_info[addr[9:2]], {1'b1, 1'b0, size, DATA_ID}, "load arsize and arid");
        end
        @(negedge aclk);
    endtask

    task automatic store_word(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] wdat,
                              input logic [STRB_W-1:0] strb);
        logic [DATA_W-1:0] unused;
        access_data(1'b1, 2'd2, addr, wdat, strb, unused);
        shadow[addr[9:2]] = merge_bytes(shadow[addr[9:2]], wdat, strb);
    endtask

    task automatic after_reset_state();
        compare(32'({arvalid, awvalid, wvalid, rready, bready, inst_data_ok, data_data_ok,
                     inst_addr_ok, data_addr_ok}), 32'h3, "handshake outputs after reset");
    endtask

    task automatic inst_fetches();
        logic [DATA_W-1:0] got;
        logic [ADDR_W-1:0] addr;
        for (int i = 0; i < 4; i++) begin
            addr = 32'h10 + 32'(i) * 32'h44;
            fetch_word(addr, got);
            compare(got, ~addr, "instruction fetch");
        end
    endtask

    task automatic data_loads();
        logic [DATA_W-1:0] got;
        logic [ADDR_W-1:0] addr;
        logic [SIZE_W-1:0] size;
        for (int s = 0; s < 3; s++) begin
            // Byte, half-word, word at shifting byte offsets
            addr = 32'h100 + 32'(s) * 32'h5;
            size = SIZE_W'(s);
            access_data(1'b0, size, addr, '0, '0, got);
            compare(got, ~{addr[31:2], 2'b00}, "data load");
        end
    endtask

    task automatic data_stores();
        logic [DATA_W-1:0] got;
        logic [ADDR_W-1:0] addr;
        store_word(32'h200, 32'haabb_ccdd, 4'b0011);
        store_word(32'h204, 32'h1122_3344, 4'b1000);
        store_word(32'h208, 32'h5566_7788, 4'b0110);
        for (int i = 0; i < 3; i++) begin
            addr = 32'h200 + 32'(i) * 32'h4;
            access_data(1'b0, 2'd2, addr, '0, '0, got);
            compare(got, shadow[addr[9:2]], "load after partial store");
        end
    endtask

    task automatic simultaneous_reads();
        logic [DATA_W-1:0] inst_got;
        logic [DATA_W-1:0] data_got;
        fork
            fetch_word(32'h300, inst_got);
            access_data(1'b0, 2'd2, 32'h340, '0, '0, data_got);
        join
        compare(inst_got, ~32'h300, "fetch beside a load");
        compare(data_got, ~32'h340, "load beside a fetch");
    endtask

    task automatic random_traffic();
        logic [DATA_W-1:0] got;
        logic [DATA_W-1:0] rnd;
        logic [DATA_W-1:0] kind;
        logic [ADDR_W-1:0] addr;
        for (int i = 0; i < 20; i++) begin
            // Small window so loads hit earlier stores
            rnd  = $urandom_range(7, 0);
            addr = 32'h380 + 32'({rnd[2:0], 2'b00});
            kind = $urandom_range(2, 0);
            if (kind == 0) begin
                fetch_word(addr, got);
                compare(got, shadow[addr[9:2]], "random fetch");
            end else if (kind == 1) begin
                rnd = $urandom_range(15, 1);
                store_word(addr, $urandom, rnd[3:0]);
            end else begin
                rnd = $urandom_range(2, 0);
                access_data(1'b0, rnd[1:0], addr, '0, '0, got);
                compare(got, shadow[addr[9:2]], "random load");
            end
        end
    endtask

    initial begin
        void'($urandom(32'hd1bc2510));
        aclk       = 1'b0;
        rst        = 1'b1;
        inst_req   = 1'b0;
        inst_addr  = '0;
        data_req   = 1'b0;
        data_wr    = 1'b0;
        data_size  = '0;
        data_addr  = '0;
        data_wdata = '0;
        data_wstrb = '0;
        for (int i = 0; i < 256; i++) begin
            shadow[i] = ~(32'(i) << 2);
        end
        repeat (16) @(posedge aclk);
        @(negedge aclk);
        rst = 1'b0;
        @(negedge aclk);
        after_reset_state();
        inst_fetches();
        data_loads();
        data_stores();
        simultaneous_reads();
        random_traffic();
        if (u_dut.u_sva.fail_count == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- testbench/tb_mem_bridge_sva.sv
`default_nettype none

module tb_mem_bridge_sva import mem_bridge_pkg::*; (
    input logic              aclk,
    input logic              rst,
    input logic [ADDR_W-1:0] araddr,
    input logic              arvalid,
    input logic              arready,
    input logic              awvalid,
    input logic              awready,
    input logic              wvalid,
    input logic              wready,
    input logic              inst_addr_ok,
    input logic              inst_data_ok,
    input logic              data_addr_ok,
    input logic              data_data_ok
);
    timeunit 1ns;
    timeprecision 1ps;

    int fail_count = 0;

    ar_hold: assert property (@(posedge aclk) disable iff (rst)
        arvalid && !arready |=> arvalid && $stable(araddr))
        else begin
            $error("arvalid or araddr changed before arready");
            fail_count++;
        end

    aw_hold: assert property (@(posedge aclk) disable iff (rst)
        awvalid && !awready |=> awvalid)
        else begin
            $error("awvalid dropped before awready");
            fail_count++;
        end

    w_hold: assert property (@(posedge aclk) disable iff (rst)
        wvalid && !wready |=> wvalid)
        else begin
            $error("wvalid dropped before wready");
            fail_count++;
        end

    // A port is busy while its data_ok pulses
    ok_while_busy: assert property (@(posedge aclk) disable iff (rst)
        !(inst_data_ok && inst_addr_ok) && !(data_data_ok && data_addr_ok))
        else begin
            $error("data_ok high while addr_ok high");
            fail_count++;
        end

    inst_pulse: assert property (@(posedge aclk) disable iff (rst)
        inst_data_ok |=> !inst_data_ok)
        else begin
            $error("inst_data_ok longer than one cycle");
            fail_count++;
        end

    data_pulse: assert property (@(posedge aclk) disable iff (rst)
        data_data_ok |=> !data_data_ok)
        else begin
            $error("data_data_ok longer than one cycle");
            fail_count++;
        end

endmodule

`default_nettype wire
